// File: common/spim_params.svh
`ifndef SPIM_PARAMS_SVH
`define SPIM_PARAMS_SVH

////////////////////
// Data path
////////////////////

// Width of one serial data word
`define SPIM_DATA_W 32

// Entries in each of the transfer and receive queues
`define SPIM_FIFO_DEPTH 4

////////////////////
// Register port
////////////////////

// Byte address of the APB port, wide enough to reach STATUS at 16
`define SPIM_ADDR_W 5

`endif

// File: common/spim_xfer_pkg.sv
`include "spim_params.svh"

package spim_xfer_pkg;

    // One word on the serial lines, right-aligned
    typedef logic [`SPIM_DATA_W-1:0] spim_word_t;

    // Index of the chip select, one of four
    typedef logic [1:0] spim_csn_t;

    // Bit count minus one, so 0 moves a single bit and 31 a full word
    typedef logic [4:0] spim_nbits_t;

    // Queued transfer, 39 bits
    typedef struct packed {
        spim_csn_t   csn;
        spim_nbits_t nbits;
        spim_word_t  data;
    } spim_xfer_t;

endpackage

// File: common/spim_reg_pkg.sv
`include "spim_params.svh"

package spim_reg_pkg;

    ////////////////////
    // Register offsets
    ////////////////////

    typedef enum logic [`SPIM_ADDR_W-1:0] {
        REG_CFG    = 'd0,
        REG_TXDATA = 'd4,
        REG_CMD    = 'd8,
        REG_RXDATA = 'd12,
        REG_STATUS = 'd16
    } spim_reg_e;

    // CFG layout, polarity in bit 8 and divider in bits 7..0
    typedef struct packed {
        logic       cpol;
        logic [7:0] div;
    } spim_cfg_t;

    // STATUS layout from bit 5 down to bit 0
    typedef struct packed {
        logic       busy;
        logic       xfer_full;
        logic       rx_empty;
        logic [2:0] rx_level;
    } spim_status_t;

endpackage

// File: source/spim_fifo.sv
`timescale 1ns/1ps
`include "spim_params.svh"

module spim_fifo
#(
    parameter type payload_t = logic [`SPIM_DATA_W-1:0]
)
(
    input  logic       sys_clk_i,
    input  logic       rst_i,
    input  logic       push_i,
    input  payload_t   data_i,
    input  logic       pop_i,
    output payload_t   data_o,
    output logic       valid_o,
    output logic       full_o,
    output logic [2:0] level_o
);

    localparam int DEPTH = `SPIM_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [2:0]       level_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keep the level
            case ({do_push, do_pop})
                2'b10:   level_q <= level_q + 3'd1;
                2'b01:   level_q <= level_q - 3'd1;
                default: level_q <= level_q;
            endcase
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (do_push)
        begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    assign data_o  = mem[rd_ptr_q];
    assign valid_o = (level_q != 3'd0);
    assign full_o  = (level_q == 3'(DEPTH));
    assign level_o = level_q;

    // Producer and consumer both look at the flags before acting
    assert property (@(posedge sys_clk_i) disable iff (rst_i) push_i |-> !full_o)
        else $error("spim_fifo: push into a full queue");
    assert property (@(posedge sys_clk_i) disable iff (rst_i) pop_i |-> valid_o)
        else $error("spim_fifo: pop from an empty queue");

endmodule

// File: source/spim_apb_regs.sv
`timescale 1ns/1ps
`include "spim_params.svh"

module spim_apb_regs
(
    input  logic                      sys_clk_i,
    input  logic                      rst_i,

    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [`SPIM_ADDR_W-1:0]   paddr_i,
    input  spim_xfer_pkg::spim_word_t pwdata_i,
    output spim_xfer_pkg::spim_word_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    input  logic                      xfer_full_i,
    input  logic                      rx_valid_i,
    input  spim_xfer_pkg::spim_word_t rx_word_i,
    input  logic                      busy_i,
    input  logic [2:0]                rx_level_i,

    output spim_reg_pkg::spim_cfg_t   cfg_o,
    output logic                      xfer_push_o,
    output spim_xfer_pkg::spim_xfer_t xfer_o,
    output logic                      rx_pop_o
);

    import spim_reg_pkg::*;
    import spim_xfer_pkg::*;

    logic         access;
    logic         wr;
    logic         rd;
    logic         mapped;
    logic         cmd_wr;
    logic         rx_rd;
    spim_reg_e    reg_sel;
    spim_cfg_t    cfg_q;
    spim_word_t   tx_hold_q;
    spim_status_t status;

    // Access phase of the APB handshake, never stretched
    assign access   = psel_i && penable_i;
    assign wr       = access && pwrite_i;
    assign rd       = access && !pwrite_i;
    assign pready_o = 1'b1;

    assign reg_sel = spim_reg_e'(paddr_i);
    assign cmd_wr  = wr && (reg_sel == REG_CMD);
    assign rx_rd   = rd && (reg_sel == REG_RXDATA);

    always_comb
    begin
        case (reg_sel)
            REG_CFG, REG_TXDATA, REG_CMD, REG_RXDATA, REG_STATUS: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    ////////////////////
    // Configuration and holding word
    ////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i)
        begin
            cfg_q <= '0;
        end
        else if (wr && (reg_sel == REG_CFG))
        begin
            cfg_q <= spim_cfg_t'(pwdata_i[$bits(spim_cfg_t)-1:0]);
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (wr && (reg_sel == REG_TXDATA))
        begin
            tx_hold_q <= pwdata_i;
        end
    end

    assign cfg_o = cfg_q;

    // CMD write joins the select and count with the holding word
    assign xfer_o.csn   = pwdata_i[1:0];
    assign xfer_o.nbits = pwdata_i[6:2];
    assign xfer_o.data  = tx_hold_q;
    assign xfer_push_o  = cmd_wr && !xfer_full_i;

    assign rx_pop_o = rx_rd && rx_valid_i;

    ////////////////////
    // Read data and errors
    ////////////////////

    assign status = '{busy: busy_i, xfer_full: xfer_full_i,
                      rx_empty: !rx_valid_i, rx_level: rx_level_i};

    always_comb
    begin
        case (reg_sel)
            REG_CFG:    prdata_o = spim_word_t'(cfg_q);
            REG_TXDATA: prdata_o = tx_hold_q;
            REG_RXDATA: prdata_o = rx_word_i;
            REG_STATUS: prdata_o = spim_word_t'(status);
            default:    prdata_o = '0;
        endcase
    end

    // Rejected accesses leave both queues untouched
    assign pslverr_o = access && (!mapped || (cmd_wr && xfer_full_i) || (rx_rd && !rx_valid_i));

endmodule

// File: spim_engine/spim_engine.sv
`timescale 1ns/1ps

module spim_engine
(
    input  logic                      sys_clk_i,
    input  logic                      rst_i,
    input  spim_reg_pkg::spim_cfg_t   cfg_i,
    input  logic                      xfer_valid_i,
    input  spim_xfer_pkg::spim_xfer_t xfer_i,
    input  logic                      rx_full_i,
    input  logic                      spi_sdi_i,
    output logic                      xfer_pop_o,
    output logic                      rx_push_o,
    output spim_xfer_pkg::spim_word_t rx_word_o,
    output logic                      busy_o,
    output logic                      eot_o,
    output logic                      spi_clk_o,
    output logic [3:0]                spi_csn_o,
    output logic                      spi_sdo_o
);

    import spim_xfer_pkg::*;

    logic        busy_q;
    logic        start;
    logic        hp_end;
    logic        last_hp;
    logic [7:0]  div_cnt_q;
    logic [6:0]  edge_cnt_q;
    logic [6:0]  n_edges;
    logic        clk_phase_q;
    logic [3:0]  csn_q;
    logic        eot_q;
    spim_nbits_t nbits_q;
    spim_word_t  tx_shift_q;
    spim_word_t  rx_shift_q;

    // Hold off in the eot cycle, the receive queue level lags the push
    assign start   = !busy_q && !eot_q && xfer_valid_i && !rx_full_i;
    assign hp_end  = busy_q && (div_cnt_q == cfg_i.div);
    // Two edges per bit, then one more half period before csn rises
    assign n_edges = {({1'b0, nbits_q} + 6'd1), 1'b0};
    assign last_hp = hp_end && (edge_cnt_q == n_edges);

    ////////////////////
    // Sequencing
    ////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i)
        begin
            busy_q      <= 1'b0;
            div_cnt_q   <= '0;
            edge_cnt_q  <= '0;
            clk_phase_q <= 1'b0;
            csn_q       <= '1;
            eot_q       <= 1'b0;
        end
        else
        begin
            eot_q <= last_hp;
            if (start)
            begin
                busy_q     <= 1'b1;
                div_cnt_q  <= '0;
                edge_cnt_q <= '0;
                csn_q      <= ~(4'b0001 << xfer_i.csn);
            end
            else if (hp_end)
            begin
                div_cnt_q  <= '0;
                edge_cnt_q <= edge_cnt_q + 7'd1;
                if (last_hp)
                begin
                    busy_q <= 1'b0;
                    csn_q  <= '1;
                end
                else
                begin
                    clk_phase_q <= ~clk_phase_q;
                end
            end
            else if (busy_q)
            begin
                div_cnt_q <= div_cnt_q + 8'd1;
            end
        end
    end

    ////////////////////
    // Shift registers
    ////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (start)
        begin
            nbits_q    <= xfer_i.nbits;
            tx_shift_q <= xfer_i.data;
            rx_shift_q <= '0;
        end
        else if (hp_end && !last_hp)
        begin
            // Even edges lead and sample, odd edges trail and shift out
            if (!edge_cnt_q[0])
            begin
                rx_shift_q <= {rx_shift_q[$bits(spim_word_t)-2:0], spi_sdi_i};
            end
            else
            begin
                tx_shift_q <= tx_shift_q << 1;
            end
        end
    end

    assign xfer_pop_o = start;
    assign rx_push_o  = eot_q;
    assign rx_word_o  = rx_shift_q;
    assign busy_o     = busy_q;
    assign eot_o      = eot_q;
    assign spi_clk_o  = clk_phase_q ^ cfg_i.cpol;
    assign spi_csn_o  = csn_q;
    assign spi_sdo_o  = busy_q && tx_shift_q[nbits_q];

    assert property (@(posedge sys_clk_i) disable iff (rst_i) $onehot0(~spi_csn_o))
        else $error("spim_engine: more than one chip select low");
    // End of transfer closes a busy period
    assert property (@(posedge sys_clk_i) disable iff (rst_i)
                     eot_o |-> !busy_o && $past(busy_o))
        else $error("spim_engine: eot outside a transfer");

endmodule

// File: source/spim_top.sv
`timescale 1ns/1ps
`include "spim_params.svh"

module spim_top
(
    input  logic                      sys_clk_i,
    input  logic                      rst_i,

    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [`SPIM_ADDR_W-1:0]   paddr_i,
    input  spim_xfer_pkg::spim_word_t pwdata_i,
    output spim_xfer_pkg::spim_word_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    output logic                      eot_o,
    output logic                      spi_clk_o,
    output logic [3:0]                spi_csn_o,
    output logic                      spi_sdo_o,
    input  logic                      spi_sdi_i
);

    import spim_reg_pkg::*;
    import spim_xfer_pkg::*;

    spim_cfg_t  cfg;
    logic       busy;

    logic       xfer_push;
    spim_xfer_t xfer_in;
    logic       xfer_full;
    logic       xfer_valid;
    spim_xfer_t xfer_out;
    logic       xfer_pop;

    logic       rx_push;
    spim_word_t rx_word_in;
    logic       rx_full;
    logic       rx_valid;
    spim_word_t rx_word_out;
    logic       rx_pop;
    logic [2:0] rx_level;

    ////////////////////
    // Register stage
    ////////////////////

    spim_apb_regs u_regs
    (
        .sys_clk_i   ( sys_clk_i   ),
        .rst_i       ( rst_i       ),
        .psel_i      ( psel_i      ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .paddr_i     ( paddr_i     ),
        .pwdata_i    ( pwdata_i    ),
        .prdata_o    ( prdata_o    ),
        .pready_o    ( pready_o    ),
        .pslverr_o   ( pslverr_o   ),
        .xfer_full_i ( xfer_full   ),
        .rx_valid_i  ( rx_valid    ),
        .rx_word_i   ( rx_word_out ),
        .busy_i      ( busy        ),
        .rx_level_i  ( rx_level    ),
        .cfg_o       ( cfg         ),
        .xfer_push_o ( xfer_push   ),
        .xfer_o      ( xfer_in     ),
        .rx_pop_o    ( rx_pop      )
    );

    spim_fifo #(.payload_t(spim_xfer_t)) u_xfer_fifo
    (
        .sys_clk_i ( sys_clk_i  ),
        .rst_i     ( rst_i      ),
        .push_i    ( xfer_push  ),
        .data_i    ( xfer_in    ),
        .pop_i     ( xfer_pop   ),
        .data_o    ( xfer_out   ),
        .valid_o   ( xfer_valid ),
        .full_o    ( xfer_full  ),
        .level_o   (            )
    );

    ////////////////////
    // Shift engine and receive side
    ////////////////////

    spim_engine u_engine
    (
        .sys_clk_i    ( sys_clk_i  ),
        .rst_i        ( rst_i      ),
        .cfg_i        ( cfg        ),
        .xfer_valid_i ( xfer_valid ),
        .xfer_i       ( xfer_out   ),
        .rx_full_i    ( rx_full    ),
        .spi_sdi_i    ( spi_sdi_i  ),
        .xfer_pop_o   ( xfer_pop   ),
        .rx_push_o    ( rx_push    ),
        .rx_word_o    ( rx_word_in ),
        .busy_o       ( busy       ),
        .eot_o        ( eot_o      ),
        .spi_clk_o    ( spi_clk_o  ),
        .spi_csn_o    ( spi_csn_o  ),
        .spi_sdo_o    ( spi_sdo_o  )
    );

    spim_fifo #(.payload_t(spim_word_t)) u_rx_fifo
    (
        .sys_clk_i ( sys_clk_i   ),
        .rst_i     ( rst_i       ),
        .push_i    ( rx_push     ),
        .data_i    ( rx_word_in  ),
        .pop_i     ( rx_pop      ),
        .data_o    ( rx_word_out ),
        .valid_o   ( rx_valid    ),
        .full_o    ( rx_full     ),
        .level_o   ( rx_level    )
    );

endmodule

// File: dv/spim_clk_gen.sv
`timescale 1ns/1ps

module spim_clk_gen
(
    output logic clk_o,
    output logic rst_o
);

    // 8 ns period
    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #4;
            clk_o = ~clk_o;
        end
    end

    initial
    begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// File: dv/spim_tb.sv
`timescale 1ns/1ps
`include "spim_params.svh"

module spim_tb;

    import spim_xfer_pkg::*;
    import spim_reg_pkg::*;

    localparam int NUM_ENTRIES = 6;

    typedef struct packed {
        logic       cpol;
        logic [7:0] div;
        spim_csn_t  cs;
        int         bits;
        spim_word_t data;
    } entry_t;

    logic                    clk;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`SPIM_ADDR_W-1:0] paddr;
    spim_word_t              pwdata;
    spim_word_t              prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    eot;
    logic                    spi_clk;
    logic [3:0]              spi_csn;
    logic                    spi_sdo;
    logic                    spi_sdi;

    entry_t     table_q [NUM_ENTRIES];
    spim_word_t ovf_data [6];
    spim_word_t rdata;
    integer     seed;
    int         cycle_limit = 1000000;
    int         cycles = 0;
    int         eot_count = 0;
    int         base;

    spim_clk_gen u_clk_gen
    (
        .clk_o ( clk ),
        .rst_o ( rst )
    );

    spim_top spim_top_i
    (
        .sys_clk_i ( clk     ),
        .rst_i     ( rst     ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .eot_o     ( eot     ),
        .spi_clk_o ( spi_clk ),
        .spi_csn_o ( spi_csn ),
        .spi_sdo_o ( spi_sdo ),
        .spi_sdi_i ( spi_sdi )
    );

    // Serial loopback
    assign spi_sdi = spi_sdo;

    ////////////////////
    // Checks
    ////////////////////

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "first error reached");
    endtask

    task automatic check_word(input spim_word_t got, input spim_word_t exp, input string what);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Mismatch at %0t: %s got %h expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_status(input spim_status_t got, input spim_status_t exp,
                                input string what);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Mismatch at %0t: %s got %b expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_csn(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Mismatch at %0t: %s got %b expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            stop_with_error($sformatf("Mismatch at %0t: %s got %b expected %b",
                                      $time, what, got, exp));
        end
    endtask

    // Expected receive word keeps only the low bits of the transmit word
    function automatic spim_word_t mask_word(input spim_word_t data, input int bits);
        spim_word_t mask;
        if (bits >= 32)
        begin
            mask = '1;
        end
        else
        begin
            mask = (spim_word_t'(1) << bits) - spim_word_t'(1);
        end
        return data & mask;
    endfunction

    function automatic spim_word_t cmd_word(input spim_csn_t cs, input int bits);
        return spim_word_t'({spim_nbits_t'(bits - 1), cs});
    endfunction

    function automatic int xfer_cycles(input int bits, input int div);
        return 2 * bits * (div + 1) + 20;
    endfunction

    ////////////////////
    // APB and monitors
    ////////////////////

    task automatic apb_access(input logic write, input logic [`SPIM_ADDR_W-1:0] addr,
                              input spim_word_t wdata, output spim_word_t rd,
                              output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // Read data and error are stable in the access cycle
        @(negedge clk);
        rd  = prdata;
        err = pslverr;
        check_flag(pready, 1'b1, "pready in access cycle");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [`SPIM_ADDR_W-1:0] addr, input spim_word_t wdata,
                             input logic exp_err, input string what);
        spim_word_t unused;
        logic       err;
        apb_access(1'b1, addr, wdata, unused, err);
        check_flag(err, exp_err, {what, " pslverr"});
    endtask

    task automatic apb_read(input logic [`SPIM_ADDR_W-1:0] addr, output spim_word_t rd,
                            input logic exp_err, input string what);
        logic err;
        apb_access(1'b0, addr, '0, rd, err);
        check_flag(err, exp_err, {what, " pslverr"});
    endtask

    always @(negedge clk)
    begin
        if (eot)
        begin
            eot_count = eot_count + 1;
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            stop_with_error($sformatf("Timeout: no end of test after %0d cycles", cycle_limit));
        end
    end

    // Busy shows one low select and idle shows the clock at its polarity
    task automatic wait_for_eot(input int target, input logic check_lines,
                                input spim_csn_t cs, input logic cpol);
        while (eot_count < target)
        begin
            @(negedge clk);
            #1;
            if (check_lines && (spi_csn !== 4'hf))
            begin
                check_csn(spi_csn, ~(4'b0001 << cs), "chip select during transfer");
            end
            else if (check_lines)
            begin
                check_flag(spi_clk, cpol, "idle serial clock");
            end
        end
        repeat (3) @(negedge clk);
        #1;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial
    begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'hb04f1059;

        table_q[0] = '{1'b0, 8'd0, 2'd0, 32, '0};
        table_q[1] = '{1'b1, 8'd1, 2'd1, 8, '0};
        table_q[2] = '{1'b0, 8'd3, 2'd2, 1, '0};
        table_q[3] = '{1'b1, 8'd2, 2'd3, 17, '0};
        table_q[4] = '{1'b0, 8'd0, 2'd1, 5, '0};
        table_q[5] = '{1'b1, 8'd5, 2'd0, 31, '0};
        cycle_limit = 5 * xfer_cycles(8, 255) + 200;
        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            table_q[i].data = spim_word_t'($random(seed));
            cycle_limit += xfer_cycles(table_q[i].bits, int'(table_q[i].div));
        end
        cycle_limit = 2 * cycle_limit;

        @(negedge rst);
        apb_read(REG_STATUS, rdata, 1'b0, "STATUS read");
        check_status(spim_status_t'(rdata[$bits(spim_status_t)-1:0]),
                     '{busy: 1'b0, xfer_full: 1'b0, rx_empty: 1'b1, rx_level: 3'd0},
                     "STATUS after reset");
        check_csn(spi_csn, 4'hf, "chip selects after reset");
        check_flag(spi_clk, 1'b0, "serial clock after reset");

        foreach (table_q[i])
        begin
            apb_write(REG_CFG, spim_word_t'({table_q[i].cpol, table_q[i].div}), 1'b0, "CFG");
            apb_write(REG_TXDATA, table_q[i].data, 1'b0, "TXDATA");
            base = eot_count;
            apb_write(REG_CMD, cmd_word(table_q[i].cs, table_q[i].bits), 1'b0, "CMD");
            wait_for_eot(base + 1, 1'b1, table_q[i].cs, table_q[i].cpol);
            check_word(spim_word_t'(eot_count), spim_word_t'(base + 1), "eot pulse count");
            apb_read(REG_RXDATA, rdata, 1'b0, "RXDATA read");
            check_word(rdata, mask_word(table_q[i].data, table_q[i].bits), "received word");
        end

        // Slow first transfer keeps one item in the engine and fills the queue
        apb_write(REG_CFG, spim_word_t'({1'b0, 8'd255}), 1'b0, "CFG");
        base = eot_count;
        for (int k = 0; k < 6; k++)
        begin
            ovf_data[k] = spim_word_t'($random(seed));
            apb_write(REG_TXDATA, ovf_data[k], 1'b0, "TXDATA");
            apb_write(REG_CMD, cmd_word(spim_csn_t'(k), 8), k == 5, "CMD into queue");
        end
        wait_for_eot(base + 4, 1'b0, 2'd0, 1'b0);
        apb_read(REG_STATUS, rdata, 1'b0, "STATUS read");
        check_status(spim_status_t'(rdata[$bits(spim_status_t)-1:0]),
                     '{busy: 1'b0, xfer_full: 1'b0, rx_empty: 1'b0, rx_level: 3'd4},
                     "STATUS with full receive queue");
        for (int k = 0; k < 4; k++)
        begin
            apb_read(REG_RXDATA, rdata, 1'b0, "RXDATA read");
            check_word(rdata, mask_word(ovf_data[k], 8), "queued received word");
        end
        wait_for_eot(base + 5, 1'b0, 2'd0, 1'b0);
        apb_read(REG_RXDATA, rdata, 1'b0, "RXDATA read");
        check_word(rdata, mask_word(ovf_data[4], 8), "held back received word");
        apb_read(REG_RXDATA, rdata, 1'b1, "RXDATA read from empty queue");

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/spim_xfer_pkg.sv
common/spim_reg_pkg.sv
source/spim_fifo.sv
source/spim_apb_regs.sv
spim_engine/spim_engine.sv
source/spim_top.sv
dv/spim_clk_gen.sv
dv/spim_tb.sv

// File: Makefile
TOP = spim_tb

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
